/* dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W = 16;
    localparam int WORD_W = ADDR_W;  // word addressed, so data and address share width
    localparam int TAG_W = 13;
    localparam int OFFSET_W = 2;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int NUM_SETS = 2;
    localparam int NUM_WAYS = 2;
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int TIME_W = 16;  // access count timestamp

    // tag | index | offset, msb first
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        cache_fields_t     f;
    } cache_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH0,
        FETCH1,
        FETCH2,
        FETCH3,
        INSTALL,
        WRITE
    } dc_state_t;

endpackage

/* cache_tag_array.sv */
`timescale 1ns/100ps

module cache_tag_array (
    input  logic                            clk,
    input  logic                            reset_n,
    input  dcache_pkg::cache_addr_t         i_addr,
    input  logic                            i_touch,
    input  logic                            i_install,
    input  logic [dcache_pkg::TIME_W-1:0]   i_access_count,
    output logic                            o_hit,
    output logic [dcache_pkg::WAY_W-1:0]    o_hit_way,
    output logic [dcache_pkg::WAY_W-1:0]    o_victim_way
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid;
    logic [TAG_W-1:0]  tags [NUM_SETS][NUM_WAYS];
    logic [TIME_W-1:0] stamps [NUM_SETS][NUM_WAYS];

    logic [NUM_WAYS-1:0] match;
    logic [INDEX_W-1:0]  idx;
    logic [TAG_W-1:0]    tag;

    assign idx = i_addr.f.index;
    assign tag = i_addr.f.tag;

    // compare against every way of the set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valid[idx][w] && (tags[idx][w] == tag);
        end
    end

    assign o_hit = |match;

    always_comb begin
        o_hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin  // lowest matching way wins
            if (match[w]) begin
                o_hit_way = WAY_W'(w);
            end
        end
    end

    // true lru over two ways
    always_comb begin
        if (!valid[idx][0]) begin
            o_victim_way = WAY_W'(0);
        end else if (!valid[idx][1]) begin
            o_victim_way = WAY_W'(1);
        end else if (stamps[idx][0] < stamps[idx][1]) begin
            o_victim_way = WAY_W'(0);
        end else begin
            o_victim_way = WAY_W'(1);  // tie goes to way 1
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid <= '0;
        end else if (i_install) begin
            valid[idx][o_victim_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_install) begin
            tags[idx][o_victim_way]   <= tag;
            stamps[idx][o_victim_way] <= i_access_count;
        end else if (i_touch) begin
            stamps[idx][o_hit_way] <= i_access_count;  // read or write hit
        end
    end

endmodule

/* cache_data_array.sv */
`timescale 1ns/100ps

module cache_data_array (
    input  logic                            clk,
    input  dcache_pkg::cache_addr_t         i_addr,
    input  logic [dcache_pkg::WAY_W-1:0]    i_way,
    input  logic                            i_word_write,
    input  logic [dcache_pkg::WORD_W-1:0]   i_wdata,
    input  logic                            i_install,
    input  logic [dcache_pkg::WORDS_PER_BLOCK-1:0][dcache_pkg::WORD_W-1:0] i_fill_block,
    output logic [dcache_pkg::WORD_W-1:0]   o_word
);
    import dcache_pkg::*;

    logic [WORD_W-1:0] words [NUM_SETS][NUM_WAYS][WORDS_PER_BLOCK];

    logic [INDEX_W-1:0]  idx;
    logic [OFFSET_W-1:0] off;

    assign idx = i_addr.f.index;
    assign off = i_addr.f.offset;

    assign o_word = words[idx][i_way][off];  // async read

    always_ff @(posedge clk) begin
        if (i_install) begin
            for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
                words[idx][i_way][w] <= i_fill_block[w];
            end
        end else if (i_word_write) begin
            words[idx][i_way][off] <= i_wdata;
        end
    end

endmodule

/* dcache_controller.sv */
`timescale 1ns/100ps

module dcache_controller (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            i_read,
    input  logic                            i_write,
    input  dcache_pkg::cache_addr_t         i_addr,
    input  logic [dcache_pkg::WORD_W-1:0]   i_wdata,
    input  logic [dcache_pkg::TIME_W-1:0]   i_access_count,
    input  logic                            i_hit,
    input  logic [dcache_pkg::WORD_W-1:0]   i_array_word,
    input  logic [dcache_pkg::WORD_W-1:0]   i_mem_rdata,
    output dcache_pkg::cache_addr_t         o_lookup_addr,
    output logic                            o_touch,
    output logic                            o_word_write,
    output logic                            o_install,
    output logic                            o_victim_sel,
    output logic [dcache_pkg::WORDS_PER_BLOCK-1:0][dcache_pkg::WORD_W-1:0] o_fill_block,
    output logic [dcache_pkg::TIME_W-1:0]   o_access_count,
    output logic                            o_busy,
    output logic                            o_done,
    output logic [dcache_pkg::WORD_W-1:0]   o_rdata,
    output logic [dcache_pkg::ADDR_W-1:0]   o_mem_addr,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic [dcache_pkg::WORD_W-1:0]   o_mem_wdata
);
    import dcache_pkg::*;

    dc_state_t state;

    cache_addr_t req_addr;  // request held while busy
    cache_addr_t blk_addr;
    logic [WORD_W-1:0] req_wdata;
    logic [TIME_W-1:0] req_count;
    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] fill_buf;
    logic [WORD_W-1:0]   refill_word;
    logic [OFFSET_W-1:0] fetch_off;
    logic                idle;
    logic                read_miss;

    assign idle = (state == IDLE);
    assign read_miss = idle && i_read && !i_hit;

    assign o_lookup_addr = idle ? i_addr : req_addr;
    assign o_touch = idle && (i_read || i_write) && i_hit;
    assign o_word_write = idle && !i_read && i_write && i_hit;  // read has priority
    assign o_install = (state == INSTALL);
    assign o_victim_sel = o_install;
    assign o_fill_block = fill_buf;
    assign o_access_count = idle ? i_access_count : req_count;

    assign o_busy = !idle;
    assign o_done = o_install;
    assign o_rdata = o_done ? refill_word : i_array_word;

    // word of the block asked for in this cycle
    always_comb begin
        case (state)
            FETCH0:  fetch_off = OFFSET_W'(1);
            FETCH1:  fetch_off = OFFSET_W'(2);
            FETCH2:  fetch_off = OFFSET_W'(3);
            default: fetch_off = OFFSET_W'(0);
        endcase
    end

    always_comb begin
        blk_addr = o_lookup_addr;
        blk_addr.f.offset = fetch_off;
    end

    assign o_mem_read = read_miss || (state == FETCH0) || (state == FETCH1)
                        || (state == FETCH2);
    assign o_mem_write = (state == WRITE);
    assign o_mem_addr = o_mem_write ? req_addr.raw : blk_addr.raw;
    assign o_mem_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (i_read) begin
                        if (!i_hit) begin
                            state <= FETCH0;
                        end
                    end else if (i_write) begin
                        state <= WRITE;  // hit or miss, always written through
                    end
                end
                FETCH0:  state <= FETCH1;
                FETCH1:  state <= FETCH2;
                FETCH2:  state <= FETCH3;
                FETCH3:  state <= INSTALL;
                INSTALL: state <= IDLE;
                WRITE:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle) begin
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
        end
        if (read_miss) begin
            req_count <= i_access_count;  // install stamps with the missing request's count
        end
        case (state)
            FETCH0: fill_buf[0] <= i_mem_rdata;
            FETCH1: fill_buf[1] <= i_mem_rdata;
            FETCH2: fill_buf[2] <= i_mem_rdata;
            FETCH3: begin
                fill_buf[3] <= i_mem_rdata;
                // last word is still on the bus
                if (req_addr.f.offset == OFFSET_W'(WORDS_PER_BLOCK - 1)) begin
                    refill_word <= i_mem_rdata;
                end else begin
                    refill_word <= fill_buf[req_addr.f.offset];
                end
            end
            default: ;
        endcase
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/100ps

module dcache_top (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            i_read,
    input  logic                            i_write,
    input  dcache_pkg::cache_addr_t         i_addr,
    input  logic [dcache_pkg::WORD_W-1:0]   i_wdata,
    input  logic [dcache_pkg::TIME_W-1:0]   i_access_count,
    output logic                            o_hit,
    output logic                            o_busy,
    output logic                            o_done,
    output logic [dcache_pkg::WORD_W-1:0]   o_rdata,
    output logic [dcache_pkg::ADDR_W-1:0]   o_mem_addr,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic [dcache_pkg::WORD_W-1:0]   o_mem_wdata,
    input  logic [dcache_pkg::WORD_W-1:0]   i_mem_rdata
);
    import dcache_pkg::*;

    cache_addr_t       lookup_addr;
    logic              touch;
    logic              word_write;
    logic              install;
    logic              victim_sel;
    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] fill_block;
    logic [TIME_W-1:0] access_count;
    logic [WAY_W-1:0]  hit_way;
    logic [WAY_W-1:0]  victim_way;
    logic [WAY_W-1:0]  array_way;
    logic [WORD_W-1:0] array_word;

    assign array_way = victim_sel ? victim_way : hit_way;  // victim only during install

    dcache_controller dcache_controller_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_read         (i_read),
        .i_write        (i_write),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_access_count (i_access_count),
        .i_hit          (o_hit),
        .i_array_word   (array_word),
        .i_mem_rdata    (i_mem_rdata),
        .o_lookup_addr  (lookup_addr),
        .o_touch        (touch),
        .o_word_write   (word_write),
        .o_install      (install),
        .o_victim_sel   (victim_sel),
        .o_fill_block   (fill_block),
        .o_access_count (access_count),
        .o_busy         (o_busy),
        .o_done         (o_done),
        .o_rdata        (o_rdata),
        .o_mem_addr     (o_mem_addr),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_mem_wdata    (o_mem_wdata)
    );

    cache_tag_array cache_tag_array_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_addr         (lookup_addr),
        .i_touch        (touch),
        .i_install      (install),
        .i_access_count (access_count),
        .o_hit          (o_hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way)
    );

    cache_data_array cache_data_array_i (
        .clk            (clk),
        .i_addr         (lookup_addr),
        .i_way          (array_way),
        .i_word_write   (word_write),
        .i_wdata        (i_wdata),
        .i_install      (install),
        .i_fill_block   (fill_block),
        .o_word         (array_word)
    );

endmodule

/* tb_dcache.sv */
`timescale 1ns/100ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int TEST_CYCLES = 300;  // upper bound on the directed tests
    localparam int MAX_CYCLES = TEST_CYCLES * 6 + 200;
    localparam logic [31:0] SEED = 32'h6114_c08c;

    logic              clk = 1'b0;
    logic              reset_n;
    logic              i_read;
    logic              i_write;
    cache_addr_t       i_addr;
    logic [WORD_W-1:0] i_wdata;
    logic [TIME_W-1:0] i_access_count;
    logic              o_hit;
    logic              o_busy;
    logic              o_done;
    logic [WORD_W-1:0] o_rdata;
    logic [ADDR_W-1:0] o_mem_addr;
    logic              o_mem_read;
    logic              o_mem_write;
    logic [WORD_W-1:0] o_mem_wdata;
    logic [WORD_W-1:0] mem_rdata = '0;

    logic [WORD_W-1:0] mem [0:65535];
    int                cycle_count = 0;
    dc_state_t         dut_state;

    assign dut_state = dcache_top_i.dcache_controller_i.state;  // fsm state inside the controller

    dcache_top dcache_top_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_read         (i_read),
        .i_write        (i_write),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_access_count (i_access_count),
        .o_hit          (o_hit),
        .o_busy         (o_busy),
        .o_done         (o_done),
        .o_rdata        (o_rdata),
        .o_mem_addr     (o_mem_addr),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_mem_wdata    (o_mem_wdata),
        .i_mem_rdata    (mem_rdata)
    );

    always #50 clk = ~clk;

    // main memory with one cycle read latency
    always @(posedge clk) begin
        if (o_mem_read) begin
            mem_rdata <= mem[o_mem_addr];
        end
        if (o_mem_write) begin
            mem[o_mem_addr] = o_mem_wdata;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fill_memory();
        logic [31:0] lcg_state;
        lcg_state = SEED;
        for (int a = 0; a < 65536; a++) begin
            lcg_state = lcg_next(lcg_state);
            mem[16'(a)] = lcg_state[31:16] ^ 16'(a);  // mixes in the address
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail %s got %0h expected %0h", name, got, expected);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic set_idle();
        i_read = 1'b0;
        i_write = 1'b0;
        i_addr.raw = '0;
        i_wdata = '0;
    endtask

    task automatic hit_read(input logic [15:0] addr, input logic [15:0] count,
                            input logic [15:0] expected);
        @(negedge clk);
        i_read = 1'b1;
        i_addr.raw = addr;
        i_access_count = count;
        #1;
        check_value("o_hit", 32'(o_hit), 32'h1);
        check_value("o_busy", 32'(o_busy), 32'h0);
        check_value("o_rdata", 32'(o_rdata), 32'(expected));
        check_value("o_mem_read", 32'(o_mem_read), 32'h0);
        @(negedge clk);
        set_idle();
        #1;
        check_value("o_busy", 32'(o_busy), 32'h0);  // a hit never stalls
        check_value("o_mem_read", 32'(o_mem_read), 32'h0);
    endtask

    task automatic miss_read(input logic [15:0] addr, input logic [15:0] count,
                             input logic [15:0] expected);
        logic [15:0] base;
        base = addr & 16'hfffc;
        @(negedge clk);
        i_read = 1'b1;
        i_addr.raw = addr;
        i_access_count = count;
        #1;
        check_value("o_hit", 32'(o_hit), 32'h0);
        check_value("o_busy", 32'(o_busy), 32'h0);
        check_value("o_mem_read", 32'(o_mem_read), 32'h1);
        check_value("o_mem_addr", 32'(o_mem_addr), 32'(base));
        for (int w = 1; w < 4; w++) begin
            @(negedge clk);
            set_idle();
            #1;
            check_value("o_busy", 32'(o_busy), 32'h1);
            check_value("o_mem_read", 32'(o_mem_read), 32'h1);
            check_value("o_mem_addr", 32'(o_mem_addr), 32'(base + 16'(w)));
        end
        @(negedge clk);
        #1;
        check_value("o_mem_read", 32'(o_mem_read), 32'h0);
        check_value("o_busy", 32'(o_busy), 32'h1);
        check_value("o_done", 32'(o_done), 32'h0);
        @(negedge clk);
        #1;
        check_value("o_done", 32'(o_done), 32'h1);
        check_value("o_rdata", 32'(o_rdata), 32'(expected));
        @(negedge clk);
        #1;
        check_value("o_busy", 32'(o_busy), 32'h0);
        check_value("o_done", 32'(o_done), 32'h0);
    endtask

    task automatic write_through(input logic [15:0] addr, input logic [15:0] data,
                                 input logic [15:0] count, input logic expect_hit);
        @(negedge clk);
        i_write = 1'b1;
        i_addr.raw = addr;
        i_wdata = data;
        i_access_count = count;
        #1;
        check_value("o_hit", 32'(o_hit), 32'(expect_hit));
        check_value("o_busy", 32'(o_busy), 32'h0);
        check_value("o_mem_write", 32'(o_mem_write), 32'h0);
        @(negedge clk);
        set_idle();
        #1;
        check_value("o_busy", 32'(o_busy), 32'h1);
        check_value("o_mem_write", 32'(o_mem_write), 32'h1);
        check_value("o_mem_addr", 32'(o_mem_addr), 32'(addr));
        check_value("o_mem_wdata", 32'(o_mem_wdata), 32'(data));
        check_value("o_mem_read", 32'(o_mem_read), 32'h0);
        @(negedge clk);
        #1;
        check_value("o_busy", 32'(o_busy), 32'h0);
        check_value("o_mem_write", 32'(o_mem_write), 32'h0);
        check_value("memory word", 32'(mem[addr]), 32'(data));
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        #1;
        check_value("dut_state", 32'(dut_state), 32'(IDLE));
        check_value("o_busy", 32'(o_busy), 32'h0);
        check_value("o_done", 32'(o_done), 32'h0);
        check_value("o_mem_read", 32'(o_mem_read), 32'h0);
        check_value("o_mem_write", 32'(o_mem_write), 32'h0);
        check_value("o_hit", 32'(o_hit), 32'h0);  // all ways invalid
    endtask

    task automatic refill_on_miss();
        miss_read(16'h0126, 16'd1, mem[16'h0126]);
    endtask

    task automatic hits_after_refill();
        logic [15:0] addr;
        for (int off = 0; off < 4; off++) begin
            addr = 16'h0124 + 16'(off);
            hit_read(addr, 16'(2 + off), mem[addr]);
        end
    endtask

    task automatic update_on_write_hit();
        write_through(16'h0125, 16'hbeef, 16'd8, 1'b1);
        hit_read(16'h0125, 16'd9, 16'hbeef);
        hit_read(16'h0127, 16'd10, mem[16'h0127]);  // neighbour untouched
    endtask

    task automatic bypass_on_write_miss();
        write_through(16'h0a57, 16'h5a3c, 16'd11, 1'b0);
        miss_read(16'h0a57, 16'd12, 16'h5a3c);
        hit_read(16'h0a57, 16'd13, 16'h5a3c);
    endtask

    // three tags competing for the two ways of set 0
    task automatic lru_eviction();
        miss_read(16'h1001, 16'd10, mem[16'h1001]);
        miss_read(16'h2002, 16'd20, mem[16'h2002]);
        hit_read(16'h1001, 16'd30, mem[16'h1001]);
        miss_read(16'h3003, 16'd40, mem[16'h3003]);  // second block is older
        hit_read(16'h1001, 16'd50, mem[16'h1001]);
        hit_read(16'h3003, 16'd60, mem[16'h3003]);
        miss_read(16'h2002, 16'd70, mem[16'h2002]);
        hit_read(16'h3003, 16'd80, mem[16'h3003]);  // way 0 was the older one here
    endtask

    initial begin
        reset_n = 1'b0;
        set_idle();
        i_access_count = '0;
        fill_memory();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        idle_after_reset();
        refill_on_miss();
        hits_after_refill();
        update_on_write_hit();
        bypass_on_write_miss();
        lru_eviction();

        $display("All tests passed!");
        $finish;
    end

endmodule

/* sim.f */
dcache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
dcache_controller.sv
dcache_top.sv
tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f sim.f --top-module tb_dcache \
    --Mdir obj_dir -o tb_dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_dcache_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -Fxq 'All tests passed!'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
